/* build.f */
+incdir+hdl
hdl/memsys_pkg.sv
hdl/link_fifo.sv
hdl/word_mem.sv
hdl/link_to_mem.sv
hdl/memsys_top.sv
tests/memsys_tb.sv

/* hdl/link_fifo.sv */
`timescale 1ns/1ps

module link_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t   slots [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  // room while not full; a single held entry may leave in the same cycle
  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = slots[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr_r] <= data_i;
    end
  end

endmodule

/* hdl/link_to_mem.sv */
`timescale 1ns/1ps
`include "memsys_params.svh"

module link_to_mem
  import memsys_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_v_i,
  input  link_req_s                 req_i,
  output logic                      req_yumi_o,
  output logic                      mem_cmd_v_o,
  output mem_cmd_s                  mem_cmd_o,
  input  logic [`MEMSYS_DATA_W-1:0] mem_rdata_i,
  output logic                      rsp_v_o,
  output link_rsp_s                 rsp_o,
  input  logic                      rsp_ready_i
);

  localparam logic [`MEMSYS_ADDR_W-1:0] mem_words = `MEMSYS_ADDR_W'(`MEMSYS_MEM_WORDS);

  logic [`MEMSYS_ADDR_W-1:0]    offset;
  logic                         in_range;
  logic                         stall;
  logic                         take;

  // issue stage
  logic                         iss_v_r;
  link_op_e                     iss_op_r;
  logic                         iss_err_r;
  logic [`MEMSYS_LOAD_ID_W-1:0] iss_id_r;

  // return stage
  logic                         ret_v_r;
  link_op_e                     ret_op_r;
  logic                         ret_err_r;
  logic [`MEMSYS_LOAD_ID_W-1:0] ret_id_r;
  logic                         ret_hold_r;
  logic [`MEMSYS_DATA_W-1:0]    ret_data_r;
  logic [`MEMSYS_DATA_W-1:0]    ret_data;

  // address decode against the served window
  assign offset   = req_i.addr - `MEMSYS_BASE_ADDR;
  assign in_range = (offset < mem_words);

  // whole pipe holds while the return item cannot leave
  assign stall      = ret_v_r & ~rsp_ready_i;
  assign take       = req_v_i & ~stall;
  assign req_yumi_o = take;

  always_ff @(posedge clk) begin
    if (!reset) begin
      iss_v_r     <= 1'b0;
      ret_v_r     <= 1'b0;
      ret_hold_r  <= 1'b0;
      mem_cmd_v_o <= 1'b0;
    end else begin
      // one command per accepted in-range request
      mem_cmd_v_o <= take & in_range;
      if (!stall) begin
        iss_v_r    <= req_v_i;
        ret_v_r    <= iss_v_r;
        ret_hold_r <= 1'b0;
      end else begin
        ret_hold_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      mem_cmd_o.we   <= (req_i.op == op_store);
      mem_cmd_o.idx  <= offset[mem_idx_w-1:0];
      mem_cmd_o.data <= req_i.data;
      mem_cmd_o.mask <= req_i.mask;
    end
    if (!stall) begin
      iss_op_r  <= req_i.op;
      iss_err_r <= ~in_range;
      iss_id_r  <= req_i.load_id;
      ret_op_r  <= iss_op_r;
      ret_err_r <= iss_err_r;
      ret_id_r  <= iss_id_r;
    end
    // memory output moves on with the next command, so keep a copy
    if (stall && !ret_hold_r) begin
      ret_data_r <= mem_rdata_i;
    end
  end

  assign ret_data = ret_hold_r ? ret_data_r : mem_rdata_i;

  assign rsp_v_o       = ret_v_r;
  assign rsp_o.op      = ret_op_r;
  assign rsp_o.err     = ret_err_r;
  assign rsp_o.load_id = ret_id_r;
  // stores and errors carry a zero word
  assign rsp_o.data    = (ret_op_r == op_load && !ret_err_r) ? ret_data : '0;

endmodule

/* hdl/memsys_params.svh */
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// data word width in bits
`define MEMSYS_DATA_W 32

// link word address width
`define MEMSYS_ADDR_W 16

// width of the load id carried with each request
`define MEMSYS_LOAD_ID_W 12

// words held by the local memory
`define MEMSYS_MEM_WORDS 256

// first word address served by this endpoint
`define MEMSYS_BASE_ADDR 16'h0400

`endif

/* hdl/memsys_pkg.sv */
`include "memsys_params.svh"

package memsys_pkg;

  // index bits into the word memory
  localparam int mem_idx_w = $clog2(`MEMSYS_MEM_WORDS);

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1
  } link_op_e;

  // request as it arrives over the link
  typedef struct packed {
    link_op_e                      op;
    logic [`MEMSYS_ADDR_W-1:0]     addr;
    logic [`MEMSYS_DATA_W-1:0]     data;
    logic [`MEMSYS_DATA_W/8-1:0]   mask;
    logic [`MEMSYS_LOAD_ID_W-1:0]  load_id;
  } link_req_s;

  // one response per request, in request order
  typedef struct packed {
    link_op_e                      op;
    logic                          err;
    logic [`MEMSYS_DATA_W-1:0]     data;
    logic [`MEMSYS_LOAD_ID_W-1:0]  load_id;
  } link_rsp_s;

  // command into the word memory
  typedef struct packed {
    logic                          we;
    logic [mem_idx_w-1:0]          idx;
    logic [`MEMSYS_DATA_W-1:0]     data;
    logic [`MEMSYS_DATA_W/8-1:0]   mask;
  } mem_cmd_s;

endpackage

/* hdl/memsys_top.sv */
`timescale 1ns/1ps
`include "memsys_params.svh"

module memsys_top
  import memsys_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_v_i,
  input  link_req_s req_i,
  output logic      req_ready_o,
  output logic      rsp_v_o,
  output link_rsp_s rsp_o,
  input  logic      rsp_ready_i
);

  logic                      req_buf_v;
  link_req_s                 req_buf_data;
  logic                      req_yumi;

  logic                      mem_cmd_v;
  mem_cmd_s                  mem_cmd;
  logic [`MEMSYS_DATA_W-1:0] mem_rdata;

  logic                      eng_rsp_v;
  link_rsp_s                 eng_rsp;
  logic                      rsp_buf_ready;
  logic                      rsp_yumi;

  // output word leaves when the link takes it
  assign rsp_yumi = rsp_v_o & rsp_ready_i;

  link_fifo #(
    .payload_t(link_req_s)
  ) u_req_buf (
    .clk    (clk),
    .reset  (reset),
    .v_i    (req_v_i),
    .data_i (req_i),
    .ready_o(req_ready_o),
    .v_o    (req_buf_v),
    .data_o (req_buf_data),
    .yumi_i (req_yumi)
  );

  link_to_mem u_link_to_mem (
    .clk        (clk),
    .reset      (reset),
    .req_v_i    (req_buf_v),
    .req_i      (req_buf_data),
    .req_yumi_o (req_yumi),
    .mem_cmd_v_o(mem_cmd_v),
    .mem_cmd_o  (mem_cmd),
    .mem_rdata_i(mem_rdata),
    .rsp_v_o    (eng_rsp_v),
    .rsp_o      (eng_rsp),
    .rsp_ready_i(rsp_buf_ready)
  );

  word_mem u_word_mem (
    .clk    (clk),
    .cmd_v_i(mem_cmd_v),
    .cmd_i  (mem_cmd),
    .rdata_o(mem_rdata)
  );

  link_fifo #(
    .payload_t(link_rsp_s)
  ) u_rsp_buf (
    .clk    (clk),
    .reset  (reset),
    .v_i    (eng_rsp_v),
    .data_i (eng_rsp),
    .ready_o(rsp_buf_ready),
    .v_o    (rsp_v_o),
    .data_o (rsp_o),
    .yumi_i (rsp_yumi)
  );

endmodule

/* hdl/word_mem.sv */
`timescale 1ns/1ps
`include "memsys_params.svh"

module word_mem
  import memsys_pkg::*;
(
  input  logic                      clk,
  input  logic                      cmd_v_i,
  input  mem_cmd_s                  cmd_i,
  output logic [`MEMSYS_DATA_W-1:0] rdata_o
);

  localparam int bytes_lp = `MEMSYS_DATA_W / 8;

  logic [`MEMSYS_DATA_W-1:0] mem [`MEMSYS_MEM_WORDS];
  logic [`MEMSYS_DATA_W-1:0] cur_word;
  logic [`MEMSYS_DATA_W-1:0] merged_word;

  assign cur_word = mem[cmd_i.idx];

  // byte merge of the write data into the stored word
  always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < bytes_lp; b++) begin
      if (cmd_i.mask[b]) begin
        merged_word[b*8 +: 8] = cmd_i.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_v_i) begin
      if (cmd_i.we) begin
        mem[cmd_i.idx] <= merged_word;
        rdata_o        <= merged_word;
      end else begin
        rdata_o <= cur_word;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module memsys_tb -o memsys_sim &&
./obj_dir/memsys_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tests/memsys_tb.sv */
`timescale 1ns/1ps
`include "memsys_params.svh"

module memsys_tb
  import memsys_pkg::*;
();

  localparam int n_fill   = `MEMSYS_MEM_WORDS;
  localparam int n_basic  = 16;
  localparam int n_masked = 18;
  localparam int n_range  = 8;
  localparam int n_stream = 40;
  localparam int n_random = 120;
  localparam int total_reqs = n_fill + n_basic + n_masked + n_range + n_stream + n_random;
  // four cycles per request plus room for back-pressure stretches
  localparam int timeout_cycles = 4 * total_reqs + 1000;

  logic      clk;
  logic      reset;
  logic      req_v;
  link_req_s req;
  logic      req_ready;
  logic      rsp_v;
  link_rsp_s rsp;
  logic      rsp_ready;

  logic [`MEMSYS_DATA_W-1:0]    ref_mem [`MEMSYS_MEM_WORDS];
  link_rsp_s                    exp_q [$];
  link_rsp_s                    exp_rsp;
  logic [`MEMSYS_LOAD_ID_W-1:0] next_id;
  logic [31:0]                  lfsr_r;
  int                           errors = 0;
  int                           checked = 0;
  int                           cycle_cnt;

  memsys_top u_memsys_top (
    .clk        (clk),
    .reset      (reset),
    .req_v_i    (req_v),
    .req_i      (req),
    .req_ready_o(req_ready),
    .rsp_v_o    (rsp_v),
    .rsp_o      (rsp),
    .rsp_ready_i(rsp_ready)
  );

  always #10 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
    lfsr_r = {lfsr_r[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic logic addr_in_range(input logic [`MEMSYS_ADDR_W-1:0] a);
    int unsigned lo;
    int unsigned hi;
    lo = 32'(`MEMSYS_BASE_ADDR);
    hi = lo + `MEMSYS_MEM_WORDS;
    return (32'(a) >= lo) && (32'(a) < hi);
  endfunction

  function automatic logic [`MEMSYS_DATA_W-1:0] merge_bytes(
    input logic [`MEMSYS_DATA_W-1:0]   old_w,
    input logic [`MEMSYS_DATA_W-1:0]   new_w,
    input logic [`MEMSYS_DATA_W/8-1:0] mask
  );
    logic [`MEMSYS_DATA_W-1:0] r;
    for (int b = 0; b < `MEMSYS_DATA_W / 8; b++) begin
      r[b*8 +: 8] = mask[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
    end
    return r;
  endfunction

  // holds valid until the buffer has room, returns one cycle after the transfer
  task automatic send_req(input link_req_s r);
    req_v = 1'b1;
    req   = r;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_v = 1'b0;
  endtask

  task automatic do_store(
    input logic [`MEMSYS_ADDR_W-1:0]   addr,
    input logic [`MEMSYS_DATA_W-1:0]   data,
    input logic [`MEMSYS_DATA_W/8-1:0] mask
  );
    link_req_s             r;
    link_rsp_s             e;
    logic [mem_idx_w-1:0]  idx;
    r.op      = op_store;
    r.addr    = addr;
    r.data    = data;
    r.mask    = mask;
    r.load_id = next_id;
    e.op      = op_store;
    e.err     = ~addr_in_range(addr);
    e.data    = '0;
    e.load_id = next_id;
    if (addr_in_range(addr)) begin
      idx = mem_idx_w'(addr - `MEMSYS_BASE_ADDR);
      ref_mem[idx] = merge_bytes(ref_mem[idx], data, mask);
    end
    exp_q.push_back(e);
    next_id = next_id + 12'd1;
    send_req(r);
  endtask

  task automatic do_load(input logic [`MEMSYS_ADDR_W-1:0] addr);
    link_req_s             r;
    link_rsp_s             e;
    logic [mem_idx_w-1:0]  idx;
    r.op      = op_load;
    r.addr    = addr;
    r.data    = '0;
    r.mask    = '0;
    r.load_id = next_id;
    e.op      = op_load;
    e.err     = ~addr_in_range(addr);
    e.data    = '0;
    e.load_id = next_id;
    if (addr_in_range(addr)) begin
      idx = mem_idx_w'(addr - `MEMSYS_BASE_ADDR);
      e.data = ref_mem[idx];
    end
    exp_q.push_back(e);
    next_id = next_id + 12'd1;
    send_req(r);
  endtask

  task automatic drain_responses(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic finish_run();
    $display("run complete: %0d errors, %0d responses checked", errors, checked);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    if (rsp_v !== 1'b0) begin
      $display("Fail at %0t: rsp_v expected 0 got %b", $time, rsp_v);
      errors++;
    end
    if (req_ready !== 1'b1) begin
      $display("Fail at %0t: req_ready expected 1 got %b", $time, req_ready);
      errors++;
    end
  endtask

  // every word written once so later loads are defined
  task automatic fill_memory();
    for (int i = 0; i < n_fill; i++) begin
      do_store(`MEMSYS_BASE_ADDR + 16'(i), rand_bits(32), 4'hf);
    end
    drain_responses(100);
  endtask

  task automatic store_then_load();
    for (int i = 0; i < n_basic / 2; i++) begin
      do_store(`MEMSYS_BASE_ADDR + 16'(i * 255 / 7), rand_bits(32), 4'hf);
    end
    for (int i = 0; i < n_basic / 2; i++) begin
      do_load(`MEMSYS_BASE_ADDR + 16'(i * 255 / 7));
    end
    drain_responses(100);
  endtask

  task automatic masked_stores();
    logic [`MEMSYS_ADDR_W-1:0]   addr;
    logic [`MEMSYS_DATA_W-1:0]   data;
    logic [`MEMSYS_DATA_W/8-1:0] mask;
    for (int i = 0; i < n_masked / 3; i++) begin
      addr = `MEMSYS_BASE_ADDR + 16'(rand_bits(8));
      data = rand_bits(32);
      do_store(addr, data, 4'hf);
      data = rand_bits(32);
      mask = 4'(rand_bits(4));
      if (mask == 4'h0 || mask == 4'hf) begin
        mask = 4'b0110;
      end
      do_store(addr, data, mask);
      do_load(addr);
    end
    drain_responses(100);
  endtask

  // 0x0500 and 0x03ff alias onto in-range indices if the decode were wrong
  task automatic out_of_range_access();
    do_store(16'h0500, rand_bits(32), 4'hf);
    do_store(16'h03ff, rand_bits(32), 4'hf);
    do_store(16'hffff, rand_bits(32), 4'hf);
    do_load(16'h0000);
    do_load(16'h0501);
    do_load(16'h8400);
    do_load(`MEMSYS_BASE_ADDR);
    do_load(`MEMSYS_BASE_ADDR + 16'd255);
    drain_responses(100);
  endtask

  task automatic backpressure_order();
    logic [`MEMSYS_ADDR_W-1:0] addrs [n_stream];
    logic [`MEMSYS_DATA_W-1:0] datas [n_stream];
    logic                      stores [n_stream];
    logic                      sends_done;
    int                        len;
    // small window so stores and loads hit the same words
    for (int i = 0; i < n_stream; i++) begin
      stores[i] = lfsr_bit();
      addrs[i]  = `MEMSYS_BASE_ADDR + 16'(rand_bits(4));
      datas[i]  = rand_bits(32);
    end
    sends_done = 1'b0;
    fork
      begin
        for (int i = 0; i < n_stream; i++) begin
          if (stores[i]) begin
            do_store(addrs[i], datas[i], 4'hf);
          end else begin
            do_load(addrs[i]);
          end
        end
        sends_done = 1'b1;
      end
      begin
        while (!sends_done) begin
          len = 1 + int'(rand_bits(3));
          rsp_ready = 1'b0;
          repeat (len) @(negedge clk);
          len = 1 + int'(rand_bits(2));
          rsp_ready = 1'b1;
          repeat (len) @(negedge clk);
        end
      end
    join
    rsp_ready = 1'b1;
    drain_responses(200);
  endtask

  task automatic random_traffic();
    logic [`MEMSYS_ADDR_W-1:0]   addr;
    logic [`MEMSYS_DATA_W-1:0]   data;
    logic [`MEMSYS_DATA_W/8-1:0] mask;
    for (int i = 0; i < n_random; i++) begin
      // roughly one in eight anywhere in the address space
      if (rand_bits(3) == 0) begin
        addr = 16'(rand_bits(16));
      end else begin
        addr = `MEMSYS_BASE_ADDR + 16'(rand_bits(8));
      end
      if (lfsr_bit()) begin
        data = rand_bits(32);
        mask = 4'(rand_bits(4));
        do_store(addr, data, mask);
      end else begin
        do_load(addr);
      end
      if (rand_bits(2) == 0) begin
        @(negedge clk);
      end
    end
    drain_responses(200);
  endtask

  // response monitor
  always @(posedge clk) begin
    if (reset && rsp_v && rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t with load id %h arrived while none was outstanding",
                 $time, rsp.load_id);
        errors++;
      end else begin
        exp_rsp = exp_q.pop_front();
        checked++;
        if (rsp.op !== exp_rsp.op) begin
          $display("Fail at %0t: rsp.op expected %0d got %0d", $time, exp_rsp.op, rsp.op);
          errors++;
        end
        if (rsp.err !== exp_rsp.err) begin
          $display("Fail at %0t: rsp.err expected %b got %b", $time, exp_rsp.err, rsp.err);
          errors++;
        end
        if (rsp.data !== exp_rsp.data) begin
          $display("Fail at %0t: rsp.data expected %h got %h", $time, exp_rsp.data, rsp.data);
          errors++;
        end
        if (rsp.load_id !== exp_rsp.load_id) begin
          $display("Fail at %0t: rsp.load_id expected %h got %h",
                   $time, exp_rsp.load_id, rsp.load_id);
          errors++;
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d responses still outstanding",
             cycle_cnt, exp_q.size());
    errors++;
    finish_run();
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b0;
    req_v     = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    lfsr_r    = 32'h2f6a_e630;
    next_id   = '0;
    repeat (5) @(negedge clk);
    reset = 1'b1;

    check_reset_state();
    fill_memory();
    store_then_load();
    masked_stores();
    out_of_range_access();
    backpressure_order();
    random_traffic();

    drain_responses(100);
    repeat (10) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      errors++;
    end
    finish_run();
  end

endmodule
